/* apple_gen.sv */
`timescale 1ns/1ps

module apple_gen (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                new_apple,
	output snake_pkg::coord_x_t apple_x,
	output snake_pkg::coord_y_t apple_y
);
	import snake_pkg::*;

	logic [14:0] lfsr;
	logic [14:0] lfsr_nxt;
	coord_x_t    map_x;
	coord_y_t    map_y;

	// x^15 + x^14 + 1, fibonacci form
	assign lfsr_nxt = {lfsr[13:0], lfsr[14] ^ lfsr[13]};

	// fold raw bits back into the playable area
	always_comb
	begin
		if (lfsr_nxt[7:0] >= 8'd150)
			map_x = lfsr_nxt[7:0] - 8'd110;
		else
			map_x = lfsr_nxt[7:0] + 8'd3;
		if (lfsr_nxt[14:8] >= 7'd100)
			map_y = lfsr_nxt[14:8] - 7'd98;
		else
			map_y = lfsr_nxt[14:8] + 7'd2;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			lfsr    <= APPLE_SEED;
			apple_x <= coord_x_t'(BORDER_LO);
			apple_y <= coord_y_t'(BORDER_LO);
		end
		else if (new_apple)
		begin
			lfsr    <= lfsr_nxt;
			apple_x <= map_x;
			apple_y <= map_y;
		end
	end

	// apple never lands on the border ring
	a_apple_in: assert property (@(posedge clk) disable iff (!arst_n)
		new_apple |=> (apple_x >= coord_x_t'(BORDER_LO) && apple_x <= coord_x_t'(BORDER_X_HI)
		&& apple_y >= coord_y_t'(BORDER_LO) && apple_y <= coord_y_t'(BORDER_Y_HI)));

endmodule

/* body_if.sv */
`timescale 1ns/1ps

interface body_if;
	import snake_pkg::*;

	// pulses from the controller, one at a time
	logic load;
	logic move;
	logic grow;
	logic scan;
	// held heading used on move
	dir_e dir;

	// body state back to the controller
	coord_x_t head_x;
	coord_y_t head_y;
	len_t     len;
	logic     hit;
	// single cycle, hit is valid with it
	logic     scan_done;

	modport ctrl (
		output load, move, grow, scan, dir,
		input  head_x, head_y, len, hit, scan_done
	);

	modport body (
		input  load, move, grow, scan, dir,
		output head_x, head_y, len, hit, scan_done
	);

endinterface

/* game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       btn_left,
	input  logic       btn_right,
	input  logic       btn_down,
	input  logic       btn_up,
	input  logic [1:0] speed,
	input  logic       ate,
	body_if.ctrl       bus,
	output logic       new_apple,
	output logic       playing,
	output logic       step,
	output logic       game_over
);
	import snake_pkg::*;

	game_state_e       state;
	game_state_e       state_nxt;
	dir_e              dir_q;
	dir_e              dir_pick;
	logic              any_btn;
	logic              check_entry;
	logic [PACE_W-1:0] pace_cnt;
	logic [PACE_W-1:0] wait_cnt;
	int                base_cnt;
	int                pace_left;

	assign any_btn = btn_left | btn_right | btn_down | btn_up;

	// wait count shrinks with every grown segment, floored
	always_comb
	begin
		base_cnt  = PACE_BASE[speed];
		pace_left = base_cnt - PACE_SHRINK * (int'(bus.len) - START_LEN);
		if (pace_left < PACE_MIN)
			wait_cnt = PACE_W'(PACE_MIN);
		else
			wait_cnt = PACE_W'(pace_left);
	end

	// first pressed key wins, reversals skipped
	always_comb
	begin
		dir_pick = dir_q;
		if (btn_left && dir_q != DIR_RIGHT)
			dir_pick = DIR_LEFT;
		else if (btn_right && dir_q != DIR_LEFT)
			dir_pick = DIR_RIGHT;
		else if (btn_down && dir_q != DIR_UP)
			dir_pick = DIR_DOWN;
		else if (btn_up && dir_q != DIR_DOWN)
			dir_pick = DIR_UP;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_MENU:       if (any_btn) state_nxt = S_START_HOLD;
			S_START_HOLD: if (!any_btn) state_nxt = S_LOAD;
			S_LOAD:       state_nxt = S_MAKE_APPLE;
			S_MAKE_APPLE: state_nxt = S_WAIT;
			S_WAIT:       if (pace_cnt >= wait_cnt - 1'b1) state_nxt = S_MOVE;
			S_MOVE:       state_nxt = S_CHECK;
			S_CHECK:
			begin
				// scan result decides the outcome of this step
				if (bus.scan_done)
				begin
					if (bus.hit)
						state_nxt = S_DEAD;
					else if (ate)
						state_nxt = S_EAT;
					else
						state_nxt = S_WAIT;
				end
			end
			S_EAT:        state_nxt = S_MAKE_APPLE;
			S_DEAD:       state_nxt = S_MENU;
			default:      state_nxt = S_MENU;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= S_MENU;
			dir_q       <= DIR_LEFT;
			pace_cnt    <= '0;
			check_entry <= 1'b0;
			step        <= 1'b0;
		end
		else
		begin
			state       <= state_nxt;
			check_entry <= (state == S_MOVE);
			// step marks the cycle after the scan ends
			step        <= bus.scan_done;
			if (state == S_WAIT)
				pace_cnt <= pace_cnt + 1'b1;
			else
				pace_cnt <= '0;
			if (state == S_LOAD)
				dir_q <= DIR_LEFT;
			else if (state == S_MOVE)
				dir_q <= dir_pick;
		end
	end

	// body pulses decoded from state
	assign bus.load  = (state == S_LOAD);
	assign bus.move  = (state == S_MOVE);
	assign bus.grow  = (state == S_EAT);
	// scan kicks off once, on the first check cycle
	assign bus.scan  = (state == S_CHECK) && check_entry;
	// new heading is seen by the body during the move cycle
	assign bus.dir   = (state == S_MOVE) ? dir_pick : dir_q;

	assign new_apple = (state == S_MAKE_APPLE);
	assign game_over = (state == S_DEAD);
	assign playing   = (state != S_MENU) && (state != S_START_HOLD) && (state != S_DEAD);

	// never two body commands in one cycle
	a_one_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({bus.load, bus.move, bus.grow, bus.scan}));

	// step only right after the body finished a scan in check
	a_step_src: assert property (@(posedge clk) disable iff (!arst_n)
		step |-> $past(bus.scan_done && state == S_CHECK));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the snake testbench with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_snake \
	-f sim.f -o sim_snake > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_snake > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

/* score_keeper.sv */
`timescale 1ns/1ps

module score_keeper (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            game_over,
	input  snake_pkg::len_t len,
	output snake_pkg::len_t best_1,
	output snake_pkg::len_t best_2,
	output snake_pkg::len_t best_3
);
	import snake_pkg::*;

	len_t score;

	// segments gained this game
	assign score = len - len_t'(START_LEN);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			best_1 <= '0;
			best_2 <= '0;
			best_3 <= '0;
		end
		else if (game_over)
		begin
			// first rank strictly beaten takes the score, lower ones slide down
			if (score > best_1)
			begin
				best_3 <= best_2;
				best_2 <= best_1;
				best_1 <= score;
			end
			else if (score > best_2)
			begin
				best_3 <= best_2;
				best_2 <= score;
			end
			else if (score > best_3)
				best_3 <= score;
		end
	end

	a_ranked: assert property (@(posedge clk) disable iff (!arst_n)
		best_1 >= best_2 && best_2 >= best_3);

endmodule

/* sim.f */
snake_pkg.sv
body_if.sv
game_fsm.sv
snake_body.sv
apple_gen.sv
score_keeper.sv
snake_top.sv
tb_snake.sv

/* snake_body.sv */
`timescale 1ns/1ps

module snake_body (
	input  logic               clk,
	input  logic               arst_n,
	body_if.body               bus,
	input  snake_pkg::coord_x_t apple_x,
	input  snake_pkg::coord_y_t apple_y,
	output logic               ate
);
	import snake_pkg::*;

	// segment 0 is the head
	coord_x_t seg_x [MAX_LEN];
	coord_y_t seg_y [MAX_LEN];
	coord_x_t next_x;
	coord_y_t next_y;
	len_t     len_q;
	len_t     idx;
	logic     busy;
	logic     self_hit;
	logic     off_field;
	logic     hit_q;
	logic     done_q;

	// one square ahead of the head
	always_comb
	begin
		next_x = seg_x[0];
		next_y = seg_y[0];
		case (bus.dir)
			DIR_LEFT:  next_x = seg_x[0] - 1'b1;
			DIR_RIGHT: next_x = seg_x[0] + 1'b1;
			DIR_DOWN:  next_y = seg_y[0] + 1'b1;
			DIR_UP:    next_y = seg_y[0] - 1'b1;
			default:   next_x = seg_x[0];
		endcase
	end

	// whole store shifts so the slot past the tail keeps the old tail for growth
	always_ff @(posedge clk)
	begin
		if (bus.load)
		begin
			for (int i = 0; i < START_LEN; i++)
			begin
				seg_x[i] <= coord_x_t'(START_X + i);
				seg_y[i] <= coord_y_t'(START_Y);
			end
		end
		else if (bus.move)
		begin
			for (int i = 1; i < MAX_LEN; i++)
			begin
				seg_x[i] <= seg_x[i-1];
				seg_y[i] <= seg_y[i-1];
			end
			seg_x[0] <= next_x;
			seg_y[0] <= next_y;
		end
	end

	assign off_field = (seg_x[0] < coord_x_t'(BORDER_LO)) || (seg_x[0] > coord_x_t'(BORDER_X_HI))
		|| (seg_y[0] < coord_y_t'(BORDER_LO)) || (seg_y[0] > coord_y_t'(BORDER_Y_HI));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			len_q    <= len_t'(START_LEN);
			idx      <= '0;
			busy     <= 1'b0;
			self_hit <= 1'b0;
			hit_q    <= 1'b0;
			done_q   <= 1'b0;
			ate      <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (bus.load)
			begin
				len_q <= len_t'(START_LEN);
				busy  <= 1'b0;
				hit_q <= 1'b0;
				ate   <= 1'b0;
			end
			else if (bus.grow)
			begin
				if (len_q < len_t'(MAX_LEN))
					len_q <= len_q + 1'b1;
			end
			else if (bus.scan)
			begin
				// head itself is skipped
				busy     <= 1'b1;
				idx      <= len_t'(1);
				self_hit <= 1'b0;
			end
			else if (busy)
			begin
				if (idx < len_q)
				begin
					if (seg_x[idx[IDX_W-1:0]] == seg_x[0] && seg_y[idx[IDX_W-1:0]] == seg_y[0])
						self_hit <= 1'b1;
					idx <= idx + 1'b1;
				end
				else
				begin
					// last scan cycle checks border and apple
					busy   <= 1'b0;
					done_q <= 1'b1;
					hit_q  <= self_hit | off_field;
					ate    <= (seg_x[0] == apple_x) && (seg_y[0] == apple_y);
				end
			end
		end
	end

	assign bus.head_x    = seg_x[0];
	assign bus.head_y    = seg_y[0];
	assign bus.len       = len_q;
	assign bus.hit       = hit_q;
	assign bus.scan_done = done_q;

	// length in range whenever the controller is driving a game
	a_len_range: assert property (@(posedge clk) disable iff (!arst_n)
		(bus.move || bus.grow || bus.scan)
		|-> (len_q >= len_t'(START_LEN) && len_q <= len_t'(MAX_LEN)));

endmodule

/* snake_pkg.sv */
package snake_pkg;

	// playfield size in squares
	localparam int FIELD_W = 160;
	localparam int FIELD_H = 120;

	// playable area, the border ring lies outside
	localparam int BORDER_LO   = 2;
	localparam int BORDER_X_HI = FIELD_W - 3;
	localparam int BORDER_Y_HI = FIELD_H - 3;

	// head start square, body trails off to the right
	localparam int START_X   = 30;
	localparam int START_Y   = 20;
	localparam int START_LEN = 5;

	// body store capacity, length saturates here
	localparam int MAX_LEN = 32;
	localparam int IDX_W   = $clog2(MAX_LEN);

	// wait counts per speed setting, in clock cycles
	localparam int PACE_BASE [4] = '{40, 24, 16, 8};
	localparam int PACE_SHRINK   = 1;
	localparam int PACE_MIN      = 4;
	localparam int PACE_W        = 6;

	// apple LFSR start value
	localparam logic [14:0] APPLE_SEED = 15'h0001;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [5:0] len_t;

	typedef enum logic [1:0] {
		DIR_LEFT  = 2'b00,
		DIR_RIGHT = 2'b01,
		DIR_DOWN  = 2'b10,
		DIR_UP    = 2'b11
	} dir_e;

	typedef enum logic [3:0] {
		S_MENU,
		S_START_HOLD,
		S_LOAD,
		S_MAKE_APPLE,
		S_WAIT,
		S_MOVE,
		S_CHECK,
		S_EAT,
		S_DEAD
	} game_state_e;

endpackage

/* snake_top.sv */
`timescale 1ns/1ps

module snake_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                btn_left,
	input  logic                btn_right,
	input  logic                btn_down,
	input  logic                btn_up,
	input  logic [1:0]          speed,
	output logic                playing,
	output logic                step,
	output logic                game_over,
	output snake_pkg::coord_x_t head_x,
	output snake_pkg::coord_y_t head_y,
	output snake_pkg::len_t     length,
	output snake_pkg::coord_x_t apple_x,
	output snake_pkg::coord_y_t apple_y,
	output snake_pkg::len_t     best_1,
	output snake_pkg::len_t     best_2,
	output snake_pkg::len_t     best_3
);

	logic new_apple;
	logic ate;

	// controller to body link
	body_if u_bus ();

	game_fsm u_game_fsm (
		.clk       (clk),
		.arst_n    (arst_n),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_down  (btn_down),
		.btn_up    (btn_up),
		.speed     (speed),
		.ate       (ate),
		.bus       (u_bus.ctrl),
		.new_apple (new_apple),
		.playing   (playing),
		.step      (step),
		.game_over (game_over)
	);

	snake_body u_snake_body (
		.clk     (clk),
		.arst_n  (arst_n),
		.bus     (u_bus.body),
		.apple_x (apple_x),
		.apple_y (apple_y),
		.ate     (ate)
	);

	apple_gen u_apple_gen (
		.clk       (clk),
		.arst_n    (arst_n),
		.new_apple (new_apple),
		.apple_x   (apple_x),
		.apple_y   (apple_y)
	);

	score_keeper u_score_keeper (
		.clk       (clk),
		.arst_n    (arst_n),
		.game_over (game_over),
		.len       (u_bus.len),
		.best_1    (best_1),
		.best_2    (best_2),
		.best_3    (best_3)
	);

	assign head_x = u_bus.head_x;
	assign head_y = u_bus.head_y;
	assign length = u_bus.len;

endmodule

/* snake_vectors.txt */
# name speed exp_len exp_over, then six pairs of button code and step count
# codes 0 none, 1 left, 2 right, 3 down, 4 up; unused pairs are 0 0
start_idle       3  5 0  0  3  0  0  0  0  0  0  0  0  0  0
reverse_ignored  3  5 0  2  2  0  0  0  0  0  0  0  0  0  0
eat_first        3  6 0  1 20  4 18  0  0  0  0  0  0  0  0
eat_row          3  8 0  2  2  2  4  0  0  0  0  0  0  0  0
border_top       3  8 1  4  1  0  0  0  0  0  0  0  0  0  0
self_hit         2  5 1  3  1  2  1  4  1  0  0  0  0  0  0
border_right     3  7 1  4 18  2 37  2 64  2 27  0  0  0  0
left_then_up     1  6 1  1 27  4 16  4  3  0  0  0  0  0  0
slow_down        0  5 0  3  5  0  0  0  0  0  0  0  0  0  0
border_bottom    3  5 1  3 93  0  0  0  0  0  0  0  0  0  0
long_game_a      3  8 0  4  2  1 27  3 16  3 32  2  1  0  0
long_game_b      3 10 1  4 64  2  2  2  3  4  1  0  0  0  0

/* tb_snake.sv */
`timescale 1ns/1ps

module tb_snake;
	import snake_pkg::*;

	localparam int STEP_TIMEOUT  = 200;
	localparam int START_TIMEOUT = 20;

	logic       clk;
	logic       arst_n;
	logic       btn_left;
	logic       btn_right;
	logic       btn_down;
	logic       btn_up;
	logic [1:0] speed;
	logic       playing;
	logic       step;
	logic       game_over;
	coord_x_t   head_x;
	coord_y_t   head_y;
	len_t       length;
	coord_x_t   apple_x;
	coord_y_t   apple_y;
	len_t       best_1;
	len_t       best_2;
	len_t       best_3;

	// reference model of the game
	int          m_x [MAX_LEN];
	int          m_y [MAX_LEN];
	int          m_len;
	dir_e        m_dir;
	logic [14:0] m_lfsr;
	int          m_apple_x;
	int          m_apple_y;
	int          m_best [3];
	logic        m_alive;

	// button sequence of the current vector line
	int    seq_code [6];
	int    seq_count [6];
	string cur_test;
	int    err_cnt;
	int    test_err;
	int    test_cnt;
	int    fail_cnt;
	logic  aborted;
	logic  seen_over;

	snake_top u_snake_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_down  (btn_down),
		.btn_up    (btn_up),
		.speed     (speed),
		.playing   (playing),
		.step      (step),
		.game_over (game_over),
		.head_x    (head_x),
		.head_y    (head_y),
		.length    (length),
		.apple_x   (apple_x),
		.apple_y   (apple_y),
		.best_1    (best_1),
		.best_2    (best_2),
		.best_3    (best_3)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_value(input string what, input int exp_v, input int act_v);
		$display("Error: test %s, %s expected %0d, actual %0d", cur_test, what, exp_v, act_v);
		err_cnt++;
		test_err++;
	endtask

	task automatic check_coord_x(input string what, input coord_x_t exp_v, input coord_x_t act_v);
		if (act_v !== exp_v)
			report_value(what, int'(exp_v), int'(act_v));
	endtask

	task automatic check_coord_y(input string what, input coord_y_t exp_v, input coord_y_t act_v);
		if (act_v !== exp_v)
			report_value(what, int'(exp_v), int'(act_v));
	endtask

	task automatic check_len(input string what, input len_t exp_v, input len_t act_v);
		if (act_v !== exp_v)
			report_value(what, int'(exp_v), int'(act_v));
	endtask

	task automatic check_bit(input string what, input logic exp_v, input logic act_v);
		if (act_v !== exp_v)
			report_value(what, int'(exp_v), int'(act_v));
	endtask

	task automatic note_timeout(input string what);
		$display("timeout in test %s: %s never came", cur_test, what);
		aborted = 1'b1;
		err_cnt++;
		test_err++;
	endtask

	// x^15 + x^14 + 1, then the raw bits folded onto the field
	task automatic model_next_apple();
		logic fb;
		int   raw_x;
		int   raw_y;
		fb        = m_lfsr[14] ^ m_lfsr[13];
		m_lfsr    = {m_lfsr[13:0], fb};
		raw_x     = int'(m_lfsr[7:0]);
		raw_y     = int'(m_lfsr[14:8]);
		m_apple_x = (raw_x >= 150) ? raw_x - 110 : raw_x + 3;
		m_apple_y = (raw_y >= 100) ? raw_y - 98 : raw_y + 2;
	endtask

	task automatic model_load();
		for (int i = 0; i < START_LEN; i++)
		begin
			m_x[i] = START_X + i;
			m_y[i] = START_Y;
		end
		m_len   = START_LEN;
		m_dir   = DIR_LEFT;
		m_alive = 1'b1;
		model_next_apple();
	endtask

	// codes 1..4 are left, right, down, up; reversal keeps the heading
	function automatic dir_e turn_dir(input int code, input dir_e cur);
		case (code)
			1: return (cur == DIR_RIGHT) ? cur : DIR_LEFT;
			2: return (cur == DIR_LEFT) ? cur : DIR_RIGHT;
			3: return (cur == DIR_UP) ? cur : DIR_DOWN;
			4: return (cur == DIR_DOWN) ? cur : DIR_UP;
			default: return cur;
		endcase
	endfunction

	// ranked table, a tie does not displace an entry
	task automatic insert_score(input int s);
		if (s > m_best[0])
		begin
			m_best[2] = m_best[1];
			m_best[1] = m_best[0];
			m_best[0] = s;
		end
		else if (s > m_best[1])
		begin
			m_best[2] = m_best[1];
			m_best[1] = s;
		end
		else if (s > m_best[2])
			m_best[2] = s;
	endtask

	task automatic model_step(input int code);
		int   hx;
		int   hy;
		logic hit;
		m_dir = turn_dir(code, m_dir);
		hx    = m_x[0];
		hy    = m_y[0];
		case (m_dir)
			DIR_LEFT:  hx = hx - 1;
			DIR_RIGHT: hx = hx + 1;
			DIR_DOWN:  hy = hy + 1;
			default:   hy = hy - 1;
		endcase
		// body follows the head
		for (int i = MAX_LEN - 1; i > 0; i--)
		begin
			m_x[i] = m_x[i-1];
			m_y[i] = m_y[i-1];
		end
		m_x[0] = hx;
		m_y[0] = hy;
		hit = (hx < BORDER_LO) || (hx > BORDER_X_HI) || (hy < BORDER_LO) || (hy > BORDER_Y_HI);
		for (int i = 1; i < m_len; i++)
			if (m_x[i] == hx && m_y[i] == hy)
				hit = 1'b1;
		if (hit)
		begin
			m_alive = 1'b0;
			insert_score(m_len - START_LEN);
		end
		else if (hx == m_apple_x && hy == m_apple_y)
		begin
			if (m_len < MAX_LEN)
				m_len++;
			model_next_apple();
		end
	endtask

	task automatic drive_buttons(input int code);
		btn_left  = (code == 1);
		btn_right = (code == 2);
		btn_down  = (code == 3);
		btn_up    = (code == 4);
	endtask

	task automatic check_scores();
		check_len("best_1", len_t'(m_best[0]), best_1);
		check_len("best_2", len_t'(m_best[1]), best_2);
		check_len("best_3", len_t'(m_best[2]), best_3);
	endtask

	task automatic check_body_state();
		check_coord_x("head x", coord_x_t'(m_x[0]), head_x);
		check_coord_y("head y", coord_y_t'(m_y[0]), head_y);
		check_len("length", len_t'(m_len), length);
		check_coord_x("apple x", coord_x_t'(m_apple_x), apple_x);
		check_coord_y("apple y", coord_y_t'(m_apple_y), apple_y);
	endtask

	// press and release, then load and apple take one cycle each
	task automatic start_game();
		int cycles;
		drive_buttons(1);
		repeat (2) @(negedge clk);
		drive_buttons(0);
		cycles = 0;
		@(negedge clk);
		while (!playing && cycles < START_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!playing)
			note_timeout("playing after start");
		else
		begin
			model_load();
			repeat (2) @(negedge clk);
			check_bit("playing", 1'b1, playing);
			check_body_state();
		end
	endtask

	task automatic run_step(input int code);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!step && cycles < STEP_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!step)
			note_timeout("step pulse");
		else
		begin
			model_step(code);
			seen_over = game_over;
			check_bit("game over", !m_alive, game_over);
			check_coord_x("head x", coord_x_t'(m_x[0]), head_x);
			check_coord_y("head y", coord_y_t'(m_y[0]), head_y);
			if (!m_alive)
			begin
				// let go before the menu sees a press
				drive_buttons(0);
				@(negedge clk);
				check_bit("playing", 1'b0, playing);
				check_scores();
			end
			else
			begin
				// grow, then new apple
				repeat (2) @(negedge clk);
				check_body_state();
			end
		end
	endtask

	task automatic finish_test();
		test_cnt++;
		if (test_err == 0)
			$display("test %s: ok", cur_test);
		else
		begin
			fail_cnt++;
			$display("test %s: %0d errors", cur_test, test_err);
		end
	endtask

	task automatic run_vector(input string tname, input int spd, input int exp_len,
		input int exp_over);
		cur_test  = tname;
		test_err  = 0;
		seen_over = 1'b0;
		speed     = 2'(spd);
		// a line may carry on the game of the line before
		if (!m_alive)
			start_game();
		for (int p = 0; p < 6; p++)
			for (int s = 0; s < seq_count[p]; s++)
				if (m_alive && !aborted)
				begin
					drive_buttons(seq_code[p]);
					run_step(seq_code[p]);
				end
		check_len("final length", len_t'(exp_len), length);
		check_bit("game over seen", exp_over != 0, seen_over);
		finish_test();
	endtask

	initial
	begin
		int    fd;
		int    nf;
		int    spd;
		int    exp_len;
		int    exp_over;
		string line;
		string tname;

		arst_n   = 1'b0;
		speed    = 2'd3;
		drive_buttons(0);
		err_cnt  = 0;
		test_cnt = 0;
		fail_cnt = 0;
		aborted  = 1'b0;
		m_alive  = 1'b0;
		m_lfsr   = APPLE_SEED;
		foreach (m_best[i])
			m_best[i] = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		cur_test = "reset";
		test_err = 0;
		check_bit("playing", 1'b0, playing);
		check_bit("step", 1'b0, step);
		check_bit("game over", 1'b0, game_over);
		check_scores();
		finish_test();

		fd = $fopen("snake_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open snake_vectors.txt");
			err_cnt++;
		end
		else
		begin
			while (!$feof(fd) && !aborted)
			begin
				line = "";
				nf = $fgets(line, fd);
				if (nf > 1 && line.getc(0) != "#")
				begin
					nf = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
						tname, spd, exp_len, exp_over,
						seq_code[0], seq_count[0], seq_code[1], seq_count[1],
						seq_code[2], seq_count[2], seq_code[3], seq_count[3],
						seq_code[4], seq_count[4], seq_code[5], seq_count[5]);
					if (nf != 16)
					begin
						$display("vector line has %0d fields instead of 16: %s", nf, line);
						err_cnt++;
					end
					else
						run_vector(tname, spd, exp_len, exp_over);
				end
			end
			$fclose(fd);
		end

		$display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0 && !aborted)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
